/* Bender.yml */
package:
  name: zc_accel

sources:
  - logic/zc_pkg.sv
  - logic/zc_rx_framer.sv
  - logic/zc_field_alu.sv
  - logic/zc_tx_framer.sv
  - logic/zc_status_regs.sv
  - logic/zc_accel_top.sv
  - target: test
    files:
      - verification/tb_zc_accel.sv

/* filelist.f */
logic/zc_pkg.sv
logic/zc_rx_framer.sv
logic/zc_field_alu.sv
logic/zc_tx_framer.sv
logic/zc_status_regs.sv
logic/zc_accel_top.sv
verification/tb_zc_accel.sv

/* logic/zc_accel_top.sv */
// zc accelerator top
// rx framer -> field alu -> tx framer, with the status bank on the side
// eop in to response header out is 5 cycles, responses stay in order

module zc_accel_top #(
  parameter logic [31:0] P_ID0 = zc_pkg::ZC_ID0_DEFAULT,
  parameter logic [31:0] P_ID1 = zc_pkg::ZC_ID1_DEFAULT
) (
  input  logic             i_clk_100,
  input  logic             i_rst_main_n,
  input  zc_pkg::zc_word_t i_rx,          // host request stream
  output zc_pkg::zc_word_t o_tx,          // response stream
  input  logic             i_csr_rd,
  input  logic [3:0]       i_csr_addr,
  output logic [31:0]      o_csr_rdata,
  output logic             o_csr_rvalid
);

  zc_pkg::zc_req_t req;
  zc_pkg::zc_rsp_t rsp;
  logic            req_pulse;
  logic            drop_pulse;
  logic            rsp_pulse;

  // ----------------------------------------
  // datapath
  // ----------------------------------------
  zc_rx_framer u_rx_framer (
    .i_clk_100    (i_clk_100),
    .i_rst_main_n (i_rst_main_n),
    .i_rx         (i_rx),
    .o_req        (req),
    .o_req_pulse  (req_pulse),
    .o_drop_pulse (drop_pulse)
  );

  zc_field_alu u_field_alu (
    .i_clk_100    (i_clk_100),
    .i_rst_main_n (i_rst_main_n),
    .i_req        (req),
    .o_rsp        (rsp)
  );

  zc_tx_framer u_tx_framer (
    .i_clk_100    (i_clk_100),
    .i_rst_main_n (i_rst_main_n),
    .i_rsp        (rsp),
    .o_tx         (o_tx),
    .o_rsp_pulse  (rsp_pulse)
  );

  // host visible status
  zc_status_regs #(
    .P_ID0 (P_ID0),
    .P_ID1 (P_ID1)
  ) u_status_regs (
    .i_clk_100    (i_clk_100),
    .i_rst_main_n (i_rst_main_n),
    .i_req_pulse  (req_pulse),
    .i_drop_pulse (drop_pulse),
    .i_rsp_pulse  (rsp_pulse),
    .i_csr_rd     (i_csr_rd),
    .i_csr_addr   (i_csr_addr),
    .o_csr_rdata  (o_csr_rdata),
    .o_csr_rvalid (o_csr_rvalid)
  );

endmodule

/* logic/zc_field_alu.sv */
// zc field alu
// add, subtract and multiply modulo 2^61-1, three stage pipeline,
// one request per cycle; 2^61 = 1 mod p so the product folds by a
// single add of its high and low halves

module zc_field_alu (
  input  logic            i_clk_100,
  input  logic            i_rst_main_n,
  input  zc_pkg::zc_req_t i_req,
  output zc_pkg::zc_rsp_t o_rsp
);

  localparam logic [61:0] P_EXT = {1'b0, zc_pkg::ZC_P};

  // stage 1 registers
  logic         s1_val;
  logic [7:0]   s1_op;
  logic [15:0]  s1_tag;
  logic [61:0]  s1_sum;   // a + b, below 2p
  logic [61:0]  s1_diff;  // a - b + p, never negative
  logic [121:0] s1_prod;  // full a * b

  // stage 2 registers
  logic         s2_val;
  logic [7:0]   s2_op;
  logic [15:0]  s2_tag;
  logic [61:0]  s2_sum;
  logic [61:0]  s2_diff;
  logic [61:0]  s2_fold;  // hi + lo of product

  // stage 3 registers
  logic         s3_val;
  logic [15:0]  s3_tag;
  logic [7:0]   s3_status;
  logic [60:0]  s3_result;

  // stage 3 combinational
  logic [61:0]  sel;
  logic         legal;
  logic [61:0]  red;

  // ----------------------------------------
  // valid chain
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      s3_val <= 1'b0;
    end else begin
      s1_val <= i_req.val;
      s2_val <= s1_val;
      s3_val <= s2_val;
    end
  end

  // ----------------------------------------
  // stage 1 - raw sum, diff, product
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    s1_op   <= i_req.op;
    s1_tag  <= i_req.tag;
    s1_sum  <= {1'b0, i_req.a} + {1'b0, i_req.b};
    s1_diff <= {1'b0, i_req.a} + P_EXT - {1'b0, i_req.b};
    s1_prod <= i_req.a * i_req.b;
  end

  // ----------------------------------------
  // stage 2 - fold product
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    s2_op   <= s1_op;
    s2_tag  <= s1_tag;
    s2_sum  <= s1_sum;
    s2_diff <= s1_diff;
    // hi * 2^61 + lo = hi + lo, stays below 2p
    s2_fold <= {1'b0, s1_prod[121:61]} + {1'b0, s1_prod[60:0]};
  end

  // ----------------------------------------
  // stage 3 - select, final reduce, status
  // ----------------------------------------
  always_comb begin
    legal = 1'b1;
    case (s2_op)
      zc_pkg::ZC_OP_ADD: sel = s2_sum;
      zc_pkg::ZC_OP_SUB: sel = s2_diff;
      zc_pkg::ZC_OP_MUL: sel = s2_fold;
      default: begin
        sel   = '0;
        legal = 1'b0;  // bad opcode still answers
      end
    endcase
  end

  assign red = (sel >= P_EXT) ? (sel - P_EXT) : sel;  // one subtract is enough

  always_ff @(posedge i_clk_100) begin
    s3_tag    <= s2_tag;
    s3_status <= legal ? zc_pkg::ZC_ST_OK : zc_pkg::ZC_ST_BAD_OP;
    s3_result <= legal ? red[60:0] : '0;
  end

  always_comb begin
    o_rsp.val    = s3_val;
    o_rsp.tag    = s3_tag;
    o_rsp.status = s3_status;
    o_rsp.result = s3_result;
  end

endmodule

/* logic/zc_pkg.sv */
// zc accelerator shared definitions
// stream beat, request and response records, opcodes, status codes,
// register map and default ID words for the mod 2^61-1 field shell

package zc_pkg;

  // ----------------------------------------
  // stream beat
  // ----------------------------------------
  typedef struct packed {
    logic        val;  // beat valid
    logic        sop;  // first word of frame
    logic        eop;  // last word of frame
    logic [63:0] dat;
  } zc_word_t;

  // ----------------------------------------
  // opcodes and status
  // ----------------------------------------
  typedef enum logic [7:0] {
    ZC_OP_ADD = 8'd1,
    ZC_OP_SUB = 8'd2,
    ZC_OP_MUL = 8'd3
  } zc_op_e;  // anything else is illegal

  localparam logic [7:0] ZC_ST_OK     = 8'd0;
  localparam logic [7:0] ZC_ST_BAD_OP = 8'd1;

  // mersenne prime 2^61 - 1
  localparam logic [60:0] ZC_P = {61{1'b1}};

  // ----------------------------------------
  // request / response records
  // ----------------------------------------
  // one assembled request, operands already reduced
  typedef struct packed {
    logic        val;
    logic [7:0]  op;   // raw header opcode
    logic [15:0] tag;
    logic [60:0] a;
    logic [60:0] b;
  } zc_req_t;

  // one finished result
  typedef struct packed {
    logic        val;
    logic [15:0] tag;
    logic [7:0]  status;
    logic [60:0] result;  // zero when status is bad op
  } zc_rsp_t;

  // ----------------------------------------
  // register map
  // ----------------------------------------
  localparam logic [3:0] ZC_REG_ID0      = 4'd0;
  localparam logic [3:0] ZC_REG_ID1      = 4'd1;
  localparam logic [3:0] ZC_REG_REQ_CNT  = 4'd2;  // accepted requests
  localparam logic [3:0] ZC_REG_DROP_CNT = 4'd3;  // malformed frames
  localparam logic [3:0] ZC_REG_RSP_CNT  = 4'd4;  // responses sent

  // identification words, overridden from the top level
  localparam logic [31:0] ZC_ID0_DEFAULT = 32'h7a63_0161;
  localparam logic [31:0] ZC_ID1_DEFAULT = 32'h0001_0003;

endpackage

/* logic/zc_rx_framer.sv */
// zc rx framer
// registers the host stream and assembles three word frames
// (header, operand a, operand b) into one request; operands are taken
// as the low 61 bits and reduced mod p; malformed frames are dropped

module zc_rx_framer (
  input  logic             i_clk_100,
  input  logic             i_rst_main_n,
  input  zc_pkg::zc_word_t i_rx,
  output zc_pkg::zc_req_t  o_req,
  output logic             o_req_pulse,
  output logic             o_drop_pulse
);

  zc_pkg::zc_word_t rx_q;   // registered input beat
  logic [1:0]       beat_cnt;  // position in frame, 0 waits for sop
  logic             skip;      // discarding rest of a bad frame
  logic [7:0]       hdr_op;
  logic [15:0]      hdr_tag;
  logic [60:0]      opnd_a;
  logic [60:0]      opnd;      // reduced operand of current beat
  logic             req_val;
  logic [7:0]       req_op;
  logic [15:0]      req_tag;
  logic [60:0]      req_a;
  logic [60:0]      req_b;
  logic             drop_q;

  // input register
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      rx_q.val <= 1'b0;
      rx_q.sop <= 1'b0;
      rx_q.eop <= 1'b0;
    end else begin
      rx_q.val <= i_rx.val;
      rx_q.sop <= i_rx.sop;
      rx_q.eop <= i_rx.eop;
    end
  end

  always_ff @(posedge i_clk_100) rx_q.dat <= i_rx.dat;

  // all ones is p itself, folds to 0
  assign opnd = (rx_q.dat[60:0] == zc_pkg::ZC_P) ? '0 : rx_q.dat[60:0];

  // ----------------------------------------
  // frame tracking
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      beat_cnt <= 2'd0;
      skip     <= 1'b0;
      req_val  <= 1'b0;
      drop_q   <= 1'b0;
    end else begin
      req_val <= 1'b0;
      drop_q  <= 1'b0;
      if (rx_q.val) begin
        if (rx_q.sop) begin
          // sop mid frame kills old one, sop+eop is a one word frame
          drop_q   <= rx_q.eop || (beat_cnt != 2'd0);
          beat_cnt <= rx_q.eop ? 2'd0 : 2'd1;
          skip     <= 1'b0;
        end else if (skip) begin
          if (rx_q.eop) skip <= 1'b0;  // already counted
        end else begin
          case (beat_cnt)
            2'd0: begin  // data without sop
              drop_q <= 1'b1;
              skip   <= !rx_q.eop;
            end
            2'd1: begin
              drop_q   <= rx_q.eop;  // two word frame
              beat_cnt <= rx_q.eop ? 2'd0 : 2'd2;
            end
            default: begin
              beat_cnt <= 2'd0;
              req_val  <= rx_q.eop;
              drop_q   <= !rx_q.eop;  // too long, eat until eop
              skip     <= !rx_q.eop;
            end
          endcase
        end
      end
    end
  end

  // header and operand capture
  always_ff @(posedge i_clk_100) begin
    if (rx_q.val && rx_q.sop) begin
      hdr_op  <= rx_q.dat[7:0];
      hdr_tag <= rx_q.dat[23:8];
    end
    if (rx_q.val && !rx_q.sop && !skip && beat_cnt == 2'd1) opnd_a <= opnd;
    if (rx_q.val && !rx_q.sop && !skip && beat_cnt == 2'd2) begin
      req_op  <= hdr_op;
      req_tag <= hdr_tag;
      req_a   <= opnd_a;
      req_b   <= opnd;
    end
  end

  always_comb begin
    o_req.val = req_val;
    o_req.op  = req_op;
    o_req.tag = req_tag;
    o_req.a   = req_a;
    o_req.b   = req_b;
  end

  assign o_req_pulse  = req_val;
  assign o_drop_pulse = drop_q;

endmodule

/* logic/zc_status_regs.sv */
// zc status registers
// read-only bank for the host: two ID words and wrapping counters of
// accepted requests, dropped frames and sent responses

module zc_status_regs #(
  parameter logic [31:0] P_ID0 = zc_pkg::ZC_ID0_DEFAULT,
  parameter logic [31:0] P_ID1 = zc_pkg::ZC_ID1_DEFAULT
) (
  input  logic        i_clk_100,
  input  logic        i_rst_main_n,
  input  logic        i_req_pulse,
  input  logic        i_drop_pulse,
  input  logic        i_rsp_pulse,
  input  logic        i_csr_rd,      // read strobe
  input  logic [3:0]  i_csr_addr,
  output logic [31:0] o_csr_rdata,
  output logic        o_csr_rvalid
);

  logic [31:0] req_cnt;
  logic [31:0] drop_cnt;
  logic [31:0] rsp_cnt;

  // ----------------------------------------
  // counters, wrap at 2^32
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      req_cnt      <= '0;
      drop_cnt     <= '0;
      rsp_cnt      <= '0;
      o_csr_rvalid <= 1'b0;
    end else begin
      if (i_req_pulse) req_cnt <= req_cnt + 32'd1;
      if (i_drop_pulse) drop_cnt <= drop_cnt + 32'd1;
      if (i_rsp_pulse) rsp_cnt <= rsp_cnt + 32'd1;
      o_csr_rvalid <= i_csr_rd;  // one cycle read latency
    end
  end

  // read mux, registered
  always_ff @(posedge i_clk_100) begin
    if (i_csr_rd) begin
      case (i_csr_addr)
        zc_pkg::ZC_REG_ID0:      o_csr_rdata <= P_ID0;
        zc_pkg::ZC_REG_ID1:      o_csr_rdata <= P_ID1;
        zc_pkg::ZC_REG_REQ_CNT:  o_csr_rdata <= req_cnt;
        zc_pkg::ZC_REG_DROP_CNT: o_csr_rdata <= drop_cnt;
        zc_pkg::ZC_REG_RSP_CNT:  o_csr_rdata <= rsp_cnt;
        default:                 o_csr_rdata <= '0;  // unmapped
      endcase
    end
  end

endmodule

/* logic/zc_tx_framer.sv */
// zc tx framer
// turns each result into a two beat frame on the host stream:
// header beat with tag and status, then the zero extended result

module zc_tx_framer (
  input  logic             i_clk_100,
  input  logic             i_rst_main_n,
  input  zc_pkg::zc_rsp_t  i_rsp,
  output zc_pkg::zc_word_t o_tx,
  output logic             o_rsp_pulse
);

  logic        data_pend;  // beat state, 1 = data beat next
  logic [60:0] res_q;      // held result for the data beat
  logic        tx_val;
  logic        tx_sop;
  logic        tx_eop;
  logic [63:0] tx_dat;
  logic        pulse_q;

  // ----------------------------------------
  // beat control
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      data_pend <= 1'b0;
      tx_val    <= 1'b0;
      tx_sop    <= 1'b0;
      tx_eop    <= 1'b0;
      pulse_q   <= 1'b0;
    end else begin
      tx_val  <= 1'b0;
      tx_sop  <= 1'b0;
      tx_eop  <= 1'b0;
      pulse_q <= 1'b0;
      if (data_pend) begin
        // second beat, counted here
        data_pend <= 1'b0;
        tx_val    <= 1'b1;
        tx_eop    <= 1'b1;
        pulse_q   <= 1'b1;
      end else if (i_rsp.val) begin
        data_pend <= 1'b1;
        tx_val    <= 1'b1;
        tx_sop    <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------
  always_ff @(posedge i_clk_100) begin
    if (data_pend) begin
      tx_dat <= {3'b000, res_q};
    end else if (i_rsp.val) begin
      tx_dat <= {40'd0, i_rsp.tag, i_rsp.status};  // tag 23:8, status 7:0
      res_q  <= i_rsp.result;
    end
  end

  always_comb begin
    o_tx.val = tx_val;
    o_tx.sop = tx_sop;
    o_tx.eop = tx_eop;
    o_tx.dat = tx_dat;
  end

  assign o_rsp_pulse = pulse_q;

endmodule

/* verification/tb_zc_accel.sv */
// zc accelerator testbench
// drives random three word frames from an lfsr, predicts each response
// with wide mod p arithmetic, checks framing, tags, results, latency,
// malformed frame drops and the status counters

module tb_zc_accel;

  localparam logic [31:0] TB_ID0 = 32'h5eed_0a11;  // non default ids
  localparam logic [31:0] TB_ID1 = 32'h0000_c0de;

  logic             clk_100;
  logic             rst_main_n;
  zc_pkg::zc_word_t rx;
  zc_pkg::zc_word_t tx;
  logic             csr_rd;
  logic [3:0]       csr_addr;
  logic [31:0]      csr_rdata;
  logic             csr_rvalid;

  logic [31:0]      lfsr_q;
  int               cyc;
  int               errors;
  int               checks;
  int               err_mark;
  int               n_req;      // good frames sent
  int               n_drop;     // malformed frames sent
  int               n_exp;      // responses expected
  string            cur_test;

  zc_pkg::zc_rsp_t  exp_q[$];   // model results in request order
  int               cyc_q[$];   // expected header cycle or -1 when unchecked
  zc_pkg::zc_rsp_t  cur;
  int               cur_cyc;
  logic             in_rsp;     // header seen so data beat is next
  logic [63:0]      hdr_dat;

  zc_accel_top #(
    .P_ID0 (TB_ID0),
    .P_ID1 (TB_ID1)
  ) u_zc_accel_top (
    .i_clk_100    (clk_100),
    .i_rst_main_n (rst_main_n),
    .i_rx         (rx),
    .o_tx         (tx),
    .i_csr_rd     (csr_rd),
    .i_csr_addr   (csr_addr),
    .o_csr_rdata  (csr_rdata),
    .o_csr_rvalid (csr_rvalid)
  );

  initial begin
    clk_100 = 1'b0;
    forever #50 clk_100 = ~clk_100;
  end

  always @(posedge clk_100) cyc <= cyc + 1;  // edge count

  // ----------------------------------------
  // random source and reference model
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // galois form of x^32 + x^22 + x^2 + x + 1
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};  // one step per bit
    end
  endtask

  function automatic zc_pkg::zc_rsp_t model_rsp(input logic [7:0] op, input logic [15:0] tag,
                                               input logic [63:0] a_w, input logic [63:0] b_w);
    logic [127:0]    p;
    logic [127:0]    a;
    logic [127:0]    b;
    logic [127:0]    r;
    zc_pkg::zc_rsp_t e;
    p = {67'd0, zc_pkg::ZC_P};
    a = {67'd0, a_w[60:0]} % p;  // low 61 bits reduced mod p
    b = {67'd0, b_w[60:0]} % p;
    e.val    = 1'b1;
    e.tag    = tag;
    e.status = zc_pkg::ZC_ST_OK;
    case (op)
      zc_pkg::ZC_OP_ADD: r = (a + b) % p;
      zc_pkg::ZC_OP_SUB: r = (a + p - b) % p;
      zc_pkg::ZC_OP_MUL: r = (a * b) % p;
      default: begin
        r        = '0;
        e.status = zc_pkg::ZC_ST_BAD_OP;
      end
    endcase
    e.result = r[60:0];
    return e;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input zc_pkg::zc_word_t e,
                            input zc_pkg::zc_word_t a);
    checks++;
    if (e !== a) begin
      errors++;
      $display("MISMATCH %s expected val=%b sop=%b eop=%b dat=%h actual val=%b sop=%b eop=%b dat=%h",
               name, e.val, e.sop, e.eop, e.dat, a.val, a.sop, a.eop, a.dat);
    end
  endtask

  task automatic check_rsp(input string name, input zc_pkg::zc_rsp_t e,
                           input zc_pkg::zc_rsp_t a);
    checks++;
    if (e.tag !== a.tag || e.status !== a.status || e.result !== a.result) begin
      errors++;
      $display("MISMATCH %s expected tag=%h st=%h res=%h actual tag=%h st=%h res=%h",
               name, e.tag, e.status, e.result, a.tag, a.status, a.result);
    end
  endtask

  task automatic check_csr(input string name, input logic [31:0] e, input logic [31:0] a);
    checks++;
    if (e !== a) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, e, a);
    end
  endtask

  task automatic check_lat(input string name, input int e, input int a);
    checks++;
    if (e != a) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, e, a);
    end
  endtask

  // ----------------------------------------
  // output monitor sampling on the falling edge
  // ----------------------------------------
  always @(negedge clk_100) begin
    zc_pkg::zc_word_t w;
    zc_pkg::zc_rsp_t  act;
    if (!rst_main_n) begin
      in_rsp = 1'b0;
    end else if (in_rsp) begin
      in_rsp = 1'b0;
      w = {1'b1, 1'b0, 1'b1, {3'b000, cur.result}};  // zero extended data beat
      check_word({cur_test, " data beat"}, w, tx);
      act.val    = 1'b1;
      act.tag    = hdr_dat[23:8];
      act.status = hdr_dat[7:0];
      act.result = tx.dat[60:0];
      check_rsp({cur_test, " response"}, cur, act);
    end else if (tx.val) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: response beat seen with no request outstanding", cur_test);
      end else begin
        cur     = exp_q.pop_front();
        cur_cyc = cyc_q.pop_front();
        w = {1'b1, 1'b1, 1'b0, {40'd0, cur.tag, cur.status}};
        check_word({cur_test, " header beat"}, w, tx);
        if (cur_cyc >= 0) check_lat({cur_test, " header cycle"}, cur_cyc, cyc);
        hdr_dat = tx.dat;
        in_rsp  = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // drivers
  // ----------------------------------------
  task automatic drive_beat(input logic sop, input logic eop, input logic [63:0] dat);
    zc_pkg::zc_word_t w;
    w = {1'b1, sop, eop, dat};
    @(posedge clk_100);
    rx <= w;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_100);
      rx <= '0;
    end
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [15:0] tag,
                            input logic [63:0] a, input logic [63:0] b, input bit gaps);
    logic [63:0] g;
    bit          nogap;
    nogap = 1'b1;
    drive_beat(1'b1, 1'b0, {40'd0, tag, op});
    if (gaps) begin
      rand_bits(2, g);
      nogap = nogap && (g[1:0] == 0);
      idle(g[1:0]);
    end
    drive_beat(1'b0, 1'b0, a);
    if (gaps) begin
      rand_bits(2, g);
      nogap = nogap && (g[1:0] == 0);
      idle(g[1:0]);
    end
    drive_beat(1'b0, 1'b1, b);
    // eop is sampled on the next edge and the header follows 5 edges later
    exp_q.push_back(model_rsp(op, tag, a, b));
    cyc_q.push_back(nogap ? cyc + 7 : -1);
    n_req++;
    n_exp++;
  endtask

  task automatic rand_operand(output logic [63:0] v);
    logic [63:0] k;
    logic [63:0] r;
    rand_bits(2, k);
    rand_bits(64, r);
    case (k[1:0])
      2'd0:    v = {r[63:61], zc_pkg::ZC_P};          // equals p
      2'd1:    v = {r[63:61], zc_pkg::ZC_P - 61'd1};  // largest residue
      default: v = r;
    endcase
  endtask

  task automatic rand_frame(input bit legal, input bit gaps);
    logic [63:0] r;
    logic [63:0] t;
    logic [63:0] a;
    logic [63:0] b;
    logic [7:0]  op;
    rand_bits(8, r);
    if (legal) begin
      op = 8'(r % 3) + 8'd1;
    end else begin
      op = r[7:0];
      if (op >= 8'd1 && op <= 8'd3) op = op | 8'h80;  // push out of range
    end
    rand_bits(16, t);
    rand_operand(a);
    rand_operand(b);
    send_frame(op, t[15:0], a, b, gaps);
    if (gaps) begin
      rand_bits(2, r);
      idle(r[1:0]);
    end
  endtask

  // wait until every expected response is out
  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || in_rsp) && n < 200) begin
      @(posedge clk_100);
      rx <= '0;
      n++;
    end
    if (n >= 200) begin
      errors++;
      $display("%s: timeout, %0d responses never arrived", cur_test, exp_q.size());
    end
    idle(2);
  endtask

  task automatic read_csr(input logic [3:0] addr, output logic [31:0] data, output int lat);
    @(posedge clk_100);
    csr_rd   <= 1'b1;
    csr_addr <= addr;
    lat = 0;
    while (1) begin
      @(posedge clk_100);
      csr_rd <= 1'b0;
      lat++;
      @(negedge clk_100);
      if (csr_rvalid || lat >= 8) break;
    end
    data = csr_rdata;
    if (!csr_rvalid) begin
      errors++;
      $display("%s: timeout, no read valid for address %0d", cur_test, addr);
    end
    @(negedge clk_100);
    if (csr_rvalid) begin
      errors++;
      $display("%s: read valid stayed high longer than one cycle", cur_test);
    end
  endtask

  task automatic end_test();
    $display("test %-10s %s, %0d errors", cur_test,
             (errors == err_mark) ? "ok" : "FAIL", errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] d;
    int          lat;
    rx         = '0;
    csr_rd     = 1'b0;
    csr_addr   = '0;
    rst_main_n = 1'b0;
    lfsr_q     = 32'hbfeb_f10b;
    cyc = 0;
    errors = 0;
    checks = 0;
    err_mark = 0;
    n_req = 0;
    n_drop = 0;
    n_exp = 0;
    in_rsp = 1'b0;
    cur_test = "reset_id";
    repeat (8) @(posedge clk_100);
    rst_main_n <= 1'b1;
    idle(4);  // monitor flags any stray beat
    @(negedge clk_100);
    if (csr_rvalid) begin
      errors++;
      $display("reset_id: read valid high after reset without a read");
    end
    read_csr(zc_pkg::ZC_REG_ID0, d, lat);
    check_csr("reset_id id0", TB_ID0, d);
    check_lat("reset_id id0 latency", 1, lat);
    read_csr(zc_pkg::ZC_REG_ID1, d, lat);
    check_csr("reset_id id1", TB_ID1, d);
    check_lat("reset_id id1 latency", 1, lat);
    for (int i = 2; i <= 4; i++) begin
      read_csr(4'(i), d, lat);
      check_csr("reset_id counter", 32'd0, d);  // all counters clear
    end
    end_test();

    cur_test = "arith";
    for (int i = 0; i < 200; i++) rand_frame(1'b1, 1'b1);
    drain();
    end_test();

    cur_test = "bad_op";
    for (int i = 0; i < 20; i++) rand_frame(1'b0, 1'b1);
    drain();
    end_test();

    cur_test = "malformed";
    drive_beat(1'b1, 1'b1, 64'h0000_0000_0012_3401);  // one word
    idle(1);
    n_drop++;
    rand_frame(1'b1, 1'b0);
    drive_beat(1'b1, 1'b0, 64'h0000_0000_0012_3502);  // two words
    drive_beat(1'b0, 1'b1, 64'd5);
    idle(1);
    n_drop++;
    rand_frame(1'b1, 1'b0);
    drive_beat(1'b1, 1'b0, 64'h0000_0000_0012_3603);  // four words
    drive_beat(1'b0, 1'b0, 64'd7);
    drive_beat(1'b0, 1'b0, 64'd9);
    drive_beat(1'b0, 1'b1, 64'd11);
    idle(1);
    n_drop++;
    rand_frame(1'b1, 1'b0);
    drive_beat(1'b0, 1'b0, 64'd13);  // no sop at all
    drive_beat(1'b0, 1'b0, 64'd17);
    drive_beat(1'b0, 1'b1, 64'd19);
    idle(1);
    n_drop++;
    rand_frame(1'b1, 1'b0);
    drive_beat(1'b1, 1'b0, 64'h0000_0000_0012_3701);  // cut short by next sop
    drive_beat(1'b0, 1'b0, 64'd23);
    n_drop++;
    rand_frame(1'b1, 1'b0);
    drain();
    end_test();

    cur_test = "b2b";
    for (int i = 0; i < 30; i++) rand_frame(1'b1, 1'b0);  // every latency checked
    drain();
    end_test();

    cur_test = "counters";
    read_csr(zc_pkg::ZC_REG_REQ_CNT, d, lat);
    check_csr("counters req", 32'(n_req), d);
    read_csr(zc_pkg::ZC_REG_DROP_CNT, d, lat);
    check_csr("counters drop", 32'(n_drop), d);
    read_csr(zc_pkg::ZC_REG_RSP_CNT, d, lat);
    check_csr("counters rsp", 32'(n_exp), d);
    read_csr(4'hf, d, lat);
    check_csr("counters unmapped", 32'd0, d);
    end_test();

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
